//--- sys_top.f
hw/sys_pkg.sv
hw/sys_cmd_decoder.sv
hw/video_timing_regs.sv
hw/led_override.sv
hw/button_debounce.sv
hw/sync_polarity_fix.sv
hw/csync_gen.sv
hw/sys_top.sv
verification/sys_top_properties.sv
verification/tb_sys_top.sv

//--- verification/tb_sys_top.sv
////////////////////////////////////////
// Testbench for the housekeeping top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_sys_top;

	import sys_pkg::*;

	localparam int DEB_DIV  = 3;
	localparam int TICK_CYC = DEB_DIV + 1;

	logic        clk_sys;
	logic        resetd;
	logic        i_io_sel;
	logic        i_io_strobe;
	io_word_t    i_io_din;
	logic        i_hs_emu;
	logic        i_vs_emu;
	logic        i_csync_en;
	logic [1:0]  i_key_n;
	logic        i_btn_user_n;
	logic        i_btn_osd_n;
	logic        i_led_user;
	logic [1:0]  i_led_power;
	logic [1:0]  i_led_disk;
	logic        i_pll_locked;
	logic [7:0]  o_led;
	logic        o_btn_user;
	logic        o_btn_osd;
	logic        o_hs;
	logic        o_vs;
	logic        o_sync;
	coord_t      o_htotal;
	coord_t      o_hsstart;
	coord_t      o_hsend;
	coord_t      o_hdisp;
	coord_t      o_vtotal;
	coord_t      o_vsstart;
	coord_t      o_vsend;
	coord_t      o_vdisp;

	// Expected register contents
	coord_t      exp_tmg [TIMING_WORDS];
	logic [7:0]  exp_ov;
	logic [7:0]  exp_state;
	logic [31:0] lcg_state;
	int          errors;
	// Sync levels seen one cycle earlier
	logic        hs_d;
	logic        vs_d;

	sys_top #(
		.DEB_DIV (DEB_DIV)
	) i_sys_top (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_sel     (i_io_sel),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.i_hs_emu     (i_hs_emu),
		.i_vs_emu     (i_vs_emu),
		.i_csync_en   (i_csync_en),
		.i_key_n      (i_key_n),
		.i_btn_user_n (i_btn_user_n),
		.i_btn_osd_n  (i_btn_osd_n),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_pll_locked (i_pll_locked),
		.o_led        (o_led),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd),
		.o_hs         (o_hs),
		.o_vs         (o_vs),
		.o_sync       (o_sync),
		.o_htotal     (o_htotal),
		.o_hsstart    (o_hsstart),
		.o_hsend      (o_hsend),
		.o_hdisp      (o_hdisp),
		.o_vtotal     (o_vtotal),
		.o_vsstart    (o_vsstart),
		.o_vsend      (o_vsend),
		.o_vdisp      (o_vdisp)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic check_value(input string name, input int exp, input int act);
		assert (exp == act)
		else begin
			$display("FAIL %s: expected %0d, actual %0d", name, exp, act);
			errors++;
		end
	endtask

	task automatic report_error(input string msg);
		$display("ERROR: %s", msg);
		errors++;
	endtask

	// Status LEDs from the current inputs
	function automatic logic [7:0] status_pattern();
		logic [7:0] pat;
		pat    = '0;
		pat[6] = i_pll_locked;
		pat[4] = i_led_power[1] ? i_led_power[0] : 1'b1;
		pat[2] = i_led_disk[0];
		pat[0] = i_led_user;
		return pat;
	endfunction

	function automatic logic [7:0] expected_led();
		return (exp_ov & exp_state) | (~exp_ov & status_pattern());
	endfunction

	////////////////////////////////////////
	// Command port transfers
	////////////////////////////////////////
	task automatic send_word(input io_word_t w);
		@(posedge clk_sys);
		#2;
		i_io_din    = w;
		i_io_strobe = 1'b1;
		@(posedge clk_sys);
		#2;
		i_io_strobe = 1'b0;
	endtask

	task automatic open_cmd(input cmd_t cmd);
		@(posedge clk_sys);
		#2;
		i_io_sel = 1'b1;
		send_word({8'h00, cmd});
	endtask

	task automatic close_cmd();
		@(posedge clk_sys);
		#2;
		i_io_sel = 1'b0;
		@(posedge clk_sys);
	endtask

	task automatic wait_led(input string name);
		int n;
		n = 0;
		while (n < 4 && o_led !== expected_led()) begin
			@(negedge clk_sys);
			n++;
		end
		check_value(name, expected_led(), o_led);
	endtask

	// Derived values follow the timing rules, truncated to 12 bits
	task automatic check_timing(input string name);
		coord_t h_ss;
		coord_t h_se;
		coord_t h_tot;
		coord_t v_ss;
		coord_t v_se;
		coord_t v_tot;
		int     n;
		h_ss  = exp_tmg[0] + exp_tmg[1];
		h_se  = h_ss + exp_tmg[2];
		h_tot = h_se + exp_tmg[3];
		v_ss  = exp_tmg[4] + exp_tmg[5];
		v_se  = v_ss + exp_tmg[6];
		v_tot = v_se + exp_tmg[7];
		n = 0;
		while (n < 4 && !(o_htotal == h_tot && o_hsend == h_se && o_hsstart == h_ss &&
			o_vtotal == v_tot && o_vsend == v_se && o_vsstart == v_ss)) begin
			@(negedge clk_sys);
			n++;
		end
		check_value({name, " htotal"}, h_tot, o_htotal);
		check_value({name, " hsstart"}, h_ss, o_hsstart);
		check_value({name, " hsend"}, h_se, o_hsend);
		check_value({name, " hdisp"}, exp_tmg[0], o_hdisp);
		check_value({name, " vtotal"}, v_tot, o_vtotal);
		check_value({name, " vsstart"}, v_ss, o_vsstart);
		check_value({name, " vsend"}, v_se, o_vsend);
		check_value({name, " vdisp"}, exp_tmg[4], o_vdisp);
	endtask

	////////////////////////////////////////
	// Buttons
	////////////////////////////////////////
	task automatic wait_button(input bit osd, input bit level, input string name);
		int n;
		n = 0;
		while ((osd ? o_btn_osd : o_btn_user) !== level && n < 12 * TICK_CYC) begin
			@(negedge clk_sys);
			n++;
		end
		if ((osd ? o_btn_osd : o_btn_user) !== level)
			report_error($sformatf("%s: button output never reached %0b", name, level));
	endtask

	task automatic watch_user_low(input int cycles, input string name);
		for (int i = 0; i < cycles; i++) begin
			@(negedge clk_sys);
			if (o_btn_user !== 1'b0)
				report_error($sformatf("%s: user button set by a short press", name));
		end
	endtask

	////////////////////////////////////////
	// Sync generation
	////////////////////////////////////////
	task automatic drive_hsync(input int hi, input int lo, input int periods,
		input string name);
		logic exp;
		for (int p = 0; p < periods; p++) begin
			for (int c = 0; c < hi + lo; c++) begin
				@(posedge clk_sys);
				#2;
				i_hs_emu = (c < hi);
				@(negedge clk_sys);
				// Polarity settles after the first two periods
				if (p >= 2) begin
					exp = (hi < lo) ? i_hs_emu : ~i_hs_emu;
					check_value(name, exp, o_hs);
				end
			end
		end
	endtask

	// 64-cycle lines, 20-line frames, vsync on lines 8 to 11
	task automatic drive_frames(input bit en, input int frames, input bit check,
		input string name);
		int vs_cyc;
		int inv_cyc;
		vs_cyc  = 0;
		inv_cyc = 0;
		for (int f = 0; f < frames; f++) begin
			for (int ln = 0; ln < 20; ln++) begin
				for (int c = 0; c < 64; c++) begin
					@(posedge clk_sys);
					#2;
					i_hs_emu   = (c < 4);
					i_vs_emu   = (ln >= 8 && ln < 12);
					i_csync_en = en;
					@(negedge clk_sys);
					// Short-high vsync passes unchanged
					if (check)
						check_value({name, " vsync"}, i_vs_emu, o_vs);
					if (check && !en) begin
						check_value(name, i_hs_emu, o_sync);
					end else if (check && !vs_d) begin
						check_value(name, hs_d, o_sync);
					end else if (check && ln >= 9 && ln < 12) begin
						vs_cyc++;
						if (o_sync == ~hs_d)
							inv_cyc++;
					end
					hs_d = i_hs_emu;
					vs_d = i_vs_emu;
				end
			end
		end
		// Inverted phase apart from the shifted pulse
		if (check && en && (vs_cyc == 0 || inv_cyc * 4 < vs_cyc * 3))
			report_error($sformatf("%s: vsync phase not inverted (%0d of %0d cycles)",
				name, inv_cyc, vs_cyc));
	endtask

	initial begin
		logic [31:0] rnd;
		i_io_sel     = 1'b0;
		i_io_strobe  = 1'b0;
		i_io_din     = '0;
		i_hs_emu     = 1'b0;
		i_vs_emu     = 1'b0;
		i_csync_en   = 1'b0;
		i_key_n      = 2'b11;
		i_btn_user_n = 1'b1;
		i_btn_osd_n  = 1'b1;
		i_led_user   = 1'b0;
		i_led_power  = 2'b00;
		i_led_disk   = 2'b00;
		i_pll_locked = 1'b1;
		lcg_state    = 32'h75b9;
		errors       = 0;
		exp_ov       = '0;
		exp_state    = '0;
		hs_d         = 1'b0;
		vs_d         = 1'b0;
		resetd       = 1'b1;
		repeat (2) @(posedge clk_sys);
		#2;
		resetd = 1'b0;

		// Reset defaults
		@(negedge clk_sys);
		check_value("reset htotal", 2204, o_htotal);
		check_value("reset hsstart", 2008, o_hsstart);
		check_value("reset hsend", 2056, o_hsend);
		check_value("reset hdisp", 1920, o_hdisp);
		check_value("reset vtotal", 1125, o_vtotal);
		check_value("reset vsstart", 1084, o_vsstart);
		check_value("reset vsend", 1089, o_vsend);
		check_value("reset vdisp", 1080, o_vdisp);
		wait_led("reset led");

		// Timing load, then one extra word
		open_cmd(CMD_VIDEO_TIMING);
		for (int i = 0; i < TIMING_WORDS; i++) begin
			rnd = next_rand();
			exp_tmg[i] = rnd[11:0];
			send_word(rnd[15:0]);
		end
		check_timing("timing load");
		rnd = next_rand();
		send_word(rnd[15:0]);
		repeat (4) @(negedge clk_sys);
		check_timing("ninth word");
		close_cmd();

		// LED override, then new LED inputs
		rnd = next_rand();
		exp_ov    = rnd[15:8];
		exp_state = rnd[7:0];
		open_cmd(CMD_LED_OVERRIDE);
		send_word(rnd[15:0]);
		close_cmd();
		wait_led("led override");
		rnd = next_rand();
		@(posedge clk_sys);
		#2;
		i_led_user   = rnd[0];
		i_led_power  = rnd[2:1];
		i_led_disk   = rnd[4:3];
		i_pll_locked = rnd[5];
		wait_led("led inputs change");
		check_value("led masked bits", exp_ov & exp_state, o_led & exp_ov);

		// Debounce: short press, long press, release
		@(posedge clk_sys);
		#2;
		i_btn_user_n = 1'b0;
		watch_user_low(5 * TICK_CYC, "short press");
		@(posedge clk_sys);
		#2;
		i_btn_user_n = 1'b1;
		watch_user_low(12 * TICK_CYC, "short press");
		@(posedge clk_sys);
		#2;
		i_btn_user_n = 1'b0;
		wait_button(1'b0, 1'b1, "user press");
		@(posedge clk_sys);
		#2;
		i_btn_user_n = 1'b1;
		wait_button(1'b0, 1'b0, "user release");
		@(posedge clk_sys);
		#2;
		i_key_n[0] = 1'b0;
		wait_button(1'b1, 1'b1, "osd key press");
		@(posedge clk_sys);
		#2;
		i_key_n[0] = 1'b1;
		wait_button(1'b1, 1'b0, "osd key release");

		// Sync polarity
		drive_hsync(3, 13, 4, "hsync short high");
		drive_hsync(13, 3, 4, "hsync short low");

		// Composite sync, one settling frame per mode
		drive_frames(1'b0, 1, 1'b0, "csync warm-up");
		drive_frames(1'b0, 1, 1'b1, "csync off");
		drive_frames(1'b1, 1, 1'b0, "csync warm-up");
		drive_frames(1'b1, 2, 1'b1, "csync on");

		@(negedge clk_sys);
		$display("Errors: %0d check failures, %0d assertion failures", errors,
			i_sys_top.u_props.fail_cnt);
		if (errors == 0 && i_sys_top.u_props.fail_cnt == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/sys_top_properties.sv
////////////////////////////////////////
// Concurrent checks bound to sys_top
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_top_properties (
	input logic       clk_sys,
	input logic       resetd,
	input logic       i_timing_wr,
	input logic       i_led_wr,
	input logic       i_btn_user,
	input logic       i_btn_osd,
	input logic [7:0] i_user_hist,
	input logic [7:0] i_osd_hist,
	input logic       i_hs,
	input logic       i_sync,
	input logic       i_csync_en
);

	int fail_cnt = 0;

	// Write pulses last one cycle
	a_timing_wr_pulse: assert property (@(posedge clk_sys) disable iff (resetd)
		i_timing_wr |=> !i_timing_wr)
	else begin
		$error("timing write pulse held for more than one cycle");
		fail_cnt++;
	end

	a_led_wr_pulse: assert property (@(posedge clk_sys) disable iff (resetd)
		i_led_wr |=> !i_led_wr)
	else begin
		$error("LED write pulse held for more than one cycle");
		fail_cnt++;
	end

	////////////////////////////////////////
	// Debounced outputs move only on a unanimous history
	////////////////////////////////////////
	a_user_set: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(i_btn_user) |-> ($past(i_user_hist) == 8'hff))
	else begin
		$error("user button set while its history was mixed");
		fail_cnt++;
	end

	a_user_clr: assert property (@(posedge clk_sys) disable iff (resetd)
		$fell(i_btn_user) |-> ($past(i_user_hist) == 8'h00))
	else begin
		$error("user button cleared while its history was mixed");
		fail_cnt++;
	end

	a_osd_set: assert property (@(posedge clk_sys) disable iff (resetd)
		$rose(i_btn_osd) |-> ($past(i_osd_hist) == 8'hff))
	else begin
		$error("OSD button set while its history was mixed");
		fail_cnt++;
	end

	a_osd_clr: assert property (@(posedge clk_sys) disable iff (resetd)
		$fell(i_btn_osd) |-> ($past(i_osd_hist) == 8'h00))
	else begin
		$error("OSD button cleared while its history was mixed");
		fail_cnt++;
	end

	// Plain hsync on the sync pin when csync is off
	a_csync_bypass: assert property (@(posedge clk_sys) disable iff (resetd)
		!i_csync_en |-> (i_sync == i_hs))
	else begin
		$error("sync output differs from hsync with csync disabled");
		fail_cnt++;
	end

endmodule

bind sys_top sys_top_properties u_props (
	.clk_sys     (clk_sys),
	.resetd      (resetd),
	.i_timing_wr (timing_wr),
	.i_led_wr    (led_wr),
	.i_btn_user  (o_btn_user),
	.i_btn_osd   (o_btn_osd),
	.i_user_hist (u_debounce.hist[0]),
	.i_osd_hist  (u_debounce.hist[1]),
	.i_hs        (o_hs),
	.i_sync      (o_sync),
	.i_csync_en  (i_csync_en)
);

`default_nettype wire

//--- hw/sys_top.sv
////////////////////////////////////////
// System clock housekeeping top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_top #(
	parameter int DEB_DIV = 100000
) (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_io_sel,
	input  logic              i_io_strobe,
	input  sys_pkg::io_word_t i_io_din,
	input  logic              i_hs_emu,
	input  logic              i_vs_emu,
	input  logic              i_csync_en,
	input  logic [1:0]        i_key_n,
	input  logic              i_btn_user_n,
	input  logic              i_btn_osd_n,
	input  logic              i_led_user,
	input  logic [1:0]        i_led_power,
	input  logic [1:0]        i_led_disk,
	input  logic              i_pll_locked,
	output logic [7:0]        o_led,
	output logic              o_btn_user,
	output logic              o_btn_osd,
	output logic              o_hs,
	output logic              o_vs,
	output logic              o_sync,
	output sys_pkg::coord_t   o_htotal,
	output sys_pkg::coord_t   o_hsstart,
	output sys_pkg::coord_t   o_hsend,
	output sys_pkg::coord_t   o_hdisp,
	output sys_pkg::coord_t   o_vtotal,
	output sys_pkg::coord_t   o_vsstart,
	output sys_pkg::coord_t   o_vsend,
	output sys_pkg::coord_t   o_vdisp
);

	import sys_pkg::*;

	logic        timing_wr;
	timing_idx_t timing_idx;
	logic        led_wr;
	io_word_t    wr_data;

	////////////////////////////////////////
	// Command port and registers
	////////////////////////////////////////
	sys_cmd_decoder u_cmd_decoder (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_io_sel     (i_io_sel),
		.i_io_strobe  (i_io_strobe),
		.i_io_din     (i_io_din),
		.o_timing_wr  (timing_wr),
		.o_timing_idx (timing_idx),
		.o_led_wr     (led_wr),
		.o_wr_data    (wr_data)
	);

	video_timing_regs u_timing_regs (
		.clk_sys   (clk_sys),
		.resetd    (resetd),
		.i_wr      (timing_wr),
		.i_idx     (timing_idx),
		.i_data    (wr_data),
		.o_htotal  (o_htotal),
		.o_hsstart (o_hsstart),
		.o_hsend   (o_hsend),
		.o_hdisp   (o_hdisp),
		.o_vtotal  (o_vtotal),
		.o_vsstart (o_vsstart),
		.o_vsend   (o_vsend),
		.o_vdisp   (o_vdisp)
	);

	led_override u_led_override (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_wr         (led_wr),
		.i_data       (wr_data),
		.i_led_user   (i_led_user),
		.i_led_power  (i_led_power),
		.i_led_disk   (i_led_disk),
		.i_pll_locked (i_pll_locked),
		.o_led        (o_led)
	);

	button_debounce #(
		.DEB_DIV (DEB_DIV)
	) u_debounce (
		.clk_sys      (clk_sys),
		.resetd       (resetd),
		.i_key_n      (i_key_n),
		.i_btn_user_n (i_btn_user_n),
		.i_btn_osd_n  (i_btn_osd_n),
		.o_btn_user   (o_btn_user),
		.o_btn_osd    (o_btn_osd)
	);

	////////////////////////////////////////
	// Sync path
	////////////////////////////////////////
	sync_polarity_fix u_hs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_hs_emu),
		.o_sync  (o_hs)
	);

	sync_polarity_fix u_vs_fix (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_vs_emu),
		.o_sync  (o_vs)
	);

	// Fed from the normalized syncs
	csync_gen u_csync (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_hsync    (o_hs),
		.i_vsync    (o_vs),
		.i_csync_en (i_csync_en),
		.o_sync     (o_sync)
	);

endmodule

`default_nettype wire

//--- hw/csync_gen.sv
////////////////////////////////////////
// Composite sync generator with
// hsync/csync output select
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module csync_gen (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_hsync,
	input  logic i_vsync,
	input  logic i_csync_en,
	output logic o_sync
);

	import sys_pkg::*;

	logic                  prev_hs;
	logic [SYNC_CNT_W-1:0] h_cnt;
	logic [SYNC_CNT_W-1:0] line_len;
	logic [SYNC_CNT_W-1:0] hs_len;
	logic                  cs_hs;
	logic                  cs_vs;

	assign o_sync = i_csync_en ? (cs_vs ^ cs_hs) : i_hsync;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			prev_hs  <= 1'b0;
			h_cnt    <= '0;
			line_len <= '0;
			hs_len   <= '0;
			cs_hs    <= 1'b0;
			cs_vs    <= 1'b0;
		end else begin
			prev_hs <= i_hsync;
			h_cnt   <= h_cnt + 1'b1;

			////////////////////////////////////////
			// Line and hsync length
			////////////////////////////////////////
			if (prev_hs != i_hsync) begin
				h_cnt <= '0;
				if (i_hsync) begin
					line_len <= h_cnt - hs_len;
					cs_hs    <= 1'b0;
				end else begin
					hs_len <= h_cnt;
				end
			end

			// In vsync the phase rises one line late
			if (!i_vsync)
				cs_hs <= i_hsync;
			else if (h_cnt == line_len)
				cs_hs <= 1'b1;

			cs_vs <= i_vsync;
		end
	end

endmodule

`default_nettype wire

//--- hw/sync_polarity_fix.sv
////////////////////////////////////////
// Sync polarity normalizer
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sync_polarity_fix (
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	import sys_pkg::*;

	logic                  s1;
	logic                  s2;
	logic [SYNC_CNT_W-1:0] cnt;
	logic [SYNC_CNT_W-1:0] len_hi;
	logic [SYNC_CNT_W-1:0] len_lo;
	logic                  pol;

	// Pulse ends up on the shorter level
	assign o_sync = i_sync ^ pol;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			s1     <= 1'b0;
			s2     <= 1'b0;
			cnt    <= '0;
			len_hi <= '0;
			len_lo <= '0;
			pol    <= 1'b0;
		end else begin
			s1 <= i_sync;
			s2 <= s1;

			// Saturate on a stuck input
			if (s1 != s2)
				cnt <= '0;
			else if (~&cnt)
				cnt <= cnt + 1'b1;

			if (~s2 & s1)
				len_lo <= cnt;
			if (s2 & ~s1)
				len_hi <= cnt;

			pol <= (len_hi > len_lo);
		end
	end

endmodule

`default_nettype wire

//--- hw/button_debounce.sv
////////////////////////////////////////
// Debouncer for user and OSD buttons
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module button_debounce #(
	parameter int DEB_DIV = 100000
) (
	input  logic       clk_sys,
	input  logic       resetd,
	input  logic [1:0] i_key_n,
	input  logic       i_btn_user_n,
	input  logic       i_btn_osd_n,
	output logic       o_btn_user,
	output logic       o_btn_osd
);

	localparam int DIV_W = $clog2(DEB_DIV + 1);

	logic [DIV_W-1:0] div_cnt;
	logic             tick;
	logic [1:0]       press;
	logic [7:0]       hist [2];
	logic [1:0]       btn;

	// Index 0 is user, index 1 is OSD
	assign press[0] = ~i_btn_user_n | ~i_key_n[1];
	assign press[1] = ~i_btn_osd_n | ~i_key_n[0];

	assign tick = (div_cnt == DIV_W'(DEB_DIV));

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			div_cnt <= '0;
			btn     <= '0;
			for (int i = 0; i < 2; i++)
				hist[i] <= '0;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;
			if (tick) begin
				for (int i = 0; i < 2; i++) begin
					hist[i] <= {hist[i][6:0], press[i]};
					// Change only on a unanimous history
					if (&hist[i])
						btn[i] <= 1'b1;
					if (~|hist[i])
						btn[i] <= 1'b0;
				end
			end
		end
	end

	assign o_btn_user = btn[0];
	assign o_btn_osd  = btn[1];

endmodule

`default_nettype wire

//--- hw/led_override.sv
////////////////////////////////////////
// LED override and status pattern
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module led_override (
	input  logic              clk_sys,
	input  logic              resetd,
	input  logic              i_wr,
	input  sys_pkg::io_word_t i_data,
	input  logic              i_led_user,
	input  logic [1:0]        i_led_power,
	input  logic [1:0]        i_led_disk,
	input  logic              i_pll_locked,
	output logic [7:0]        o_led
);

	logic [7:0] overtake;
	logic [7:0] state;
	logic [7:0] status;
	logic       led_pwr;

	// Power LED stays lit unless the core takes it over
	assign led_pwr = i_led_power[1] ? i_led_power[0] : 1'b1;

	assign status = {1'b0, i_pll_locked, 1'b0, led_pwr, 1'b0, i_led_disk[0], 1'b0, i_led_user};

	always_ff @(posedge clk_sys) begin
		if (resetd)
			overtake <= '0;
		else if (i_wr)
			overtake <= i_data[15:8];
	end

	always_ff @(posedge clk_sys) begin
		if (i_wr)
			state <= i_data[7:0];
		o_led <= (overtake & state) | (~overtake & status);
	end

endmodule

`default_nettype wire

//--- hw/video_timing_regs.sv
////////////////////////////////////////
// Video timing registers and derived
// scaler timing values
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module video_timing_regs (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_wr,
	input  sys_pkg::timing_idx_t i_idx,
	input  sys_pkg::io_word_t    i_data,
	output sys_pkg::coord_t      o_htotal,
	output sys_pkg::coord_t      o_hsstart,
	output sys_pkg::coord_t      o_hsend,
	output sys_pkg::coord_t      o_hdisp,
	output sys_pkg::coord_t      o_vtotal,
	output sys_pkg::coord_t      o_vsstart,
	output sys_pkg::coord_t      o_vsend,
	output sys_pkg::coord_t      o_vdisp
);

	import sys_pkg::*;

	localparam coord_t TIMING_DEF [TIMING_WORDS] = '{
		DEF_WIDTH, DEF_HFP, DEF_HS, DEF_HBP,
		DEF_HEIGHT, DEF_VFP, DEF_VS, DEF_VBP
	};

	coord_t tmg [TIMING_WORDS];
	coord_t h_sstart;
	coord_t h_send;
	coord_t v_sstart;
	coord_t v_send;

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			for (int i = 0; i < TIMING_WORDS; i++)
				tmg[i] <= TIMING_DEF[i];
		end else if (i_wr) begin
			tmg[i_idx] <= i_data[$bits(coord_t)-1:0];
		end
	end

	// Words 0..3 horizontal, 4..7 vertical
	assign h_sstart = tmg[0] + tmg[1];
	assign h_send   = h_sstart + tmg[2];
	assign v_sstart = tmg[4] + tmg[5];
	assign v_send   = v_sstart + tmg[6];

	always_ff @(posedge clk_sys) begin
		o_hdisp   <= tmg[0];
		o_hsstart <= h_sstart;
		o_hsend   <= h_send;
		o_htotal  <= h_send + tmg[3];

		o_vdisp   <= tmg[4];
		o_vsstart <= v_sstart;
		o_vsend   <= v_send;
		o_vtotal  <= v_send + tmg[7];
	end

endmodule

`default_nettype wire

//--- hw/sys_cmd_decoder.sv
////////////////////////////////////////
// Host command port decoder
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module sys_cmd_decoder (
	input  logic                 clk_sys,
	input  logic                 resetd,
	input  logic                 i_io_sel,
	input  logic                 i_io_strobe,
	input  sys_pkg::io_word_t    i_io_din,
	output logic                 o_timing_wr,
	output sys_pkg::timing_idx_t o_timing_idx,
	output logic                 o_led_wr,
	output sys_pkg::io_word_t    o_wr_data
);

	import sys_pkg::*;

	localparam int CNT_W = $clog2(TIMING_WORDS + 1);

	logic             old_strobe;
	logic             xfer;
	logic             has_cmd;
	cmd_t             cmd;
	logic [CNT_W-1:0] word_cnt;
	logic             timing_slot;

	// Rising strobe while selected
	assign xfer = i_io_sel & i_io_strobe & ~old_strobe;

	// Words past the last timing slot are dropped
	assign timing_slot = (cmd == CMD_VIDEO_TIMING) && (word_cnt < CNT_W'(TIMING_WORDS));

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			old_strobe  <= 1'b0;
			has_cmd     <= 1'b0;
			cmd         <= '0;
			word_cnt    <= '0;
			o_timing_wr <= 1'b0;
			o_led_wr    <= 1'b0;
		end else begin
			old_strobe  <= i_io_strobe;
			o_timing_wr <= 1'b0;
			o_led_wr    <= 1'b0;

			if (!i_io_sel) begin
				has_cmd <= 1'b0;
			end else if (xfer) begin
				if (!has_cmd) begin
					// First word carries the command byte
					has_cmd  <= 1'b1;
					cmd      <= i_io_din[7:0];
					word_cnt <= '0;
				end else begin
					if (timing_slot) begin
						o_timing_wr <= 1'b1;
						word_cnt    <= word_cnt + 1'b1;
					end
					if (cmd == CMD_LED_OVERRIDE)
						o_led_wr <= 1'b1;
				end
			end
		end
	end

	// Write payload, valid alongside the pulses
	always_ff @(posedge clk_sys) begin
		if (xfer && has_cmd) begin
			o_timing_idx <= timing_idx_t'(word_cnt);
			o_wr_data    <= i_io_din;
		end
	end

endmodule

`default_nettype wire

//--- hw/sys_pkg.sv
////////////////////////////////////////
// Shared types, command codes and
// video timing defaults
////////////////////////////////////////
`default_nettype none

package sys_pkg;

	////////////////////////////////////////
	// Host port types
	////////////////////////////////////////
	typedef logic [15:0] io_word_t;
	typedef logic [7:0]  cmd_t;

	// Timing word index within command 0x20
	typedef logic [2:0]  timing_idx_t;

	// Pixel and line counts
	typedef logic [11:0] coord_t;

	////////////////////////////////////////
	// Command codes
	////////////////////////////////////////
	localparam cmd_t CMD_VIDEO_TIMING = 8'h20;
	localparam cmd_t CMD_LED_OVERRIDE = 8'h25;

	localparam int TIMING_WORDS = 8;

	////////////////////////////////////////
	// 1920x1080 defaults, in word order
	////////////////////////////////////////
	localparam coord_t DEF_WIDTH  = 12'd1920;
	localparam coord_t DEF_HFP    = 12'd88;
	localparam coord_t DEF_HS     = 12'd48;
	localparam coord_t DEF_HBP    = 12'd148;
	localparam coord_t DEF_HEIGHT = 12'd1080;
	localparam coord_t DEF_VFP    = 12'd4;
	localparam coord_t DEF_VS     = 12'd5;
	localparam coord_t DEF_VBP    = 12'd36;

	// Line and sync level length counters
	localparam int SYNC_CNT_W = 16;

endpackage

`default_nettype wire
